/* Bender.yml */
package:
  name: aos_shell

sources:
  - hw/aos_pkg.sv
  - hw/sync_fifo.sv
  - hw/softreg_router.sv
  - hw/mem_drive.sv
  - hw/mem_arbiter.sv
  - hw/simple_dram.sv
  - hw/aos_top.sv
  - target: simulation
    files:
      - verification/aos_props.sv
      - verification/aos_tb.sv

/* hw/aos_pkg.sv */
// AmorphOS memory-test shell package
// Sizes, soft-register map and the packed request/response types
`default_nettype none

package aos_pkg;

	// ------------------------------
	// Sizes
	// ------------------------------
	localparam int NUM_APPS     = 2;
	localparam int APP_ID_W     = 1;

	// Host soft-register port
	localparam int SR_ADDR_W    = 32;
	localparam int SR_DATA_W    = 64;
	// Registers sit 8 bytes apart
	localparam int REG_IDX_LSB  = 3;
	localparam int REG_IDX_W    = 3;
	// Application select above the register index
	localparam int APP_SEL_LSB  = 6;

	// Memory channel
	localparam int MEM_ADDR_W   = 10;
	localparam int MEM_DATA_W   = 64;
	localparam int MEM_DEPTH    = 1024;
	// Queue exit to read data
	localparam int DRAM_LATENCY = 4;
	localparam int FIFO_DEPTH   = 4;

	// ------------------------------
	// Register map of one application
	// ------------------------------
	localparam logic [REG_IDX_W-1:0] REG_BASE    = 3'd0;
	localparam logic [REG_IDX_W-1:0] REG_COUNT   = 3'd1;
	localparam logic [REG_IDX_W-1:0] REG_PATTERN = 3'd2;
	// Bit 0 picks write run or read run
	localparam logic [REG_IDX_W-1:0] REG_START   = 3'd3;
	// Bit 63 busy, low bits progress
	localparam logic [REG_IDX_W-1:0] REG_DONE    = 3'd4;
	localparam logic [REG_IDX_W-1:0] REG_SUM     = 3'd5;

	// ------------------------------
	// Types
	// ------------------------------
	typedef logic [APP_ID_W-1:0] app_id_t;

	// Host request, taken whenever valid
	typedef struct packed {
		logic                 valid;
		logic                 is_write;
		logic [SR_ADDR_W-1:0] addr;
		logic [SR_DATA_W-1:0] data;
	} softreg_req_t;

	// Read data back to the host
	typedef struct packed {
		logic                 valid;
		logic [SR_DATA_W-1:0] data;
	} softreg_resp_t;

	// Word request, valid/grant handshake
	typedef struct packed {
		logic                  valid;
		logic                  is_write;
		logic [MEM_ADDR_W-1:0] addr;
		logic [MEM_DATA_W-1:0] data;
	} mem_req_t;

	// Read data only, writes are silent
	typedef struct packed {
		logic                  valid;
		logic [MEM_DATA_W-1:0] data;
	} mem_resp_t;

endpackage

`default_nettype wire

/* hw/aos_top.sv */
// Top level of the memory-test shell
// Host soft registers to the apps, app memory ports to one DRAM
`timescale 1ns/1ps
`default_nettype none

module aos_top (
	input  wire logic                  clk_main_a0,
	input  wire logic                  rst_main_n,
	input  wire aos_pkg::softreg_req_t host_req,
	output aos_pkg::softreg_resp_t     host_resp
);

	// Router to apps
	aos_pkg::softreg_req_t  app_req        [aos_pkg::NUM_APPS];
	aos_pkg::softreg_resp_t app_resp       [aos_pkg::NUM_APPS];
	// Apps to arbiter
	aos_pkg::mem_req_t      app_mem_req    [aos_pkg::NUM_APPS];
	logic                   app_req_grant  [aos_pkg::NUM_APPS];
	aos_pkg::mem_resp_t     app_mem_resp   [aos_pkg::NUM_APPS];
	logic                   app_resp_grant [aos_pkg::NUM_APPS];
	// Arbiter to DRAM
	aos_pkg::mem_req_t      ch_req;
	logic                   ch_req_grant;
	aos_pkg::mem_resp_t     ch_resp;
	logic                   ch_resp_grant;

	softreg_router router_i (
		.clk_main_a0 (clk_main_a0),
		.rst_main_n  (rst_main_n),
		.host_req    (host_req),
		.host_resp   (host_resp),
		.app_req     (app_req),
		.app_resp    (app_resp)
	);

	for (genvar a = 0; a < aos_pkg::NUM_APPS; a++) begin : g_app
		mem_drive app_i (
			.clk_main_a0    (clk_main_a0),
			.rst_main_n     (rst_main_n),
			.sr_req         (app_req[a]),
			.sr_resp        (app_resp[a]),
			.mem_req        (app_mem_req[a]),
			.mem_req_grant  (app_req_grant[a]),
			.mem_resp       (app_mem_resp[a]),
			.mem_resp_grant (app_resp_grant[a])
		);
	end

	mem_arbiter arbiter_i (
		.clk_main_a0    (clk_main_a0),
		.rst_main_n     (rst_main_n),
		.app_mem_req    (app_mem_req),
		.app_req_grant  (app_req_grant),
		.app_mem_resp   (app_mem_resp),
		.app_resp_grant (app_resp_grant),
		.ch_req         (ch_req),
		.ch_req_grant   (ch_req_grant),
		.ch_resp        (ch_resp),
		.ch_resp_grant  (ch_resp_grant)
	);

	simple_dram dram_i (
		.clk_main_a0 (clk_main_a0),
		.rst_main_n  (rst_main_n),
		.req         (ch_req),
		.req_grant   (ch_req_grant),
		.resp        (ch_resp),
		.resp_grant  (ch_resp_grant)
	);

endmodule

`default_nettype wire

/* hw/mem_arbiter.sv */
// Memory arbiter
// Round-robin of the application ports onto one channel,
// read data steered back by a queue of winner tags
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input  wire logic               clk_main_a0,
	input  wire logic               rst_main_n,
	input  wire aos_pkg::mem_req_t  app_mem_req [aos_pkg::NUM_APPS],
	output logic                    app_req_grant [aos_pkg::NUM_APPS],
	output aos_pkg::mem_resp_t      app_mem_resp [aos_pkg::NUM_APPS],
	input  wire logic               app_resp_grant [aos_pkg::NUM_APPS],
	output aos_pkg::mem_req_t       ch_req,
	input  wire logic               ch_req_grant,
	input  wire aos_pkg::mem_resp_t ch_resp,
	output logic                    ch_resp_grant
);

	aos_pkg::app_id_t  rr_ptr;
	aos_pkg::app_id_t  scan_id;
	logic              scan_found;
	logic              locked;
	aos_pkg::app_id_t  lock_id;
	aos_pkg::app_id_t  winner;
	aos_pkg::mem_req_t win_req;
	logic              ch_xfer;
	logic              tag_in_grant;
	aos_pkg::app_id_t  tag_head;
	logic              tag_head_valid;
	logic              tag_pop;

	// First valid request at or after the pointer
	always_comb begin : scan_b
		aos_pkg::app_id_t idx;
		scan_id    = rr_ptr;
		scan_found = 1'b0;
		for (int k = 0; k < aos_pkg::NUM_APPS; k++) begin
			idx = aos_pkg::app_id_t'((int'(rr_ptr) + k) % aos_pkg::NUM_APPS);
			if (!scan_found && app_mem_req[idx].valid) begin
				scan_found = 1'b1;
				scan_id    = idx;
			end
		end
	end

	// A presented but ungranted request keeps the channel
	assign winner  = locked ? lock_id : scan_id;
	assign win_req = app_mem_req[winner];

	// Reads wait for room in the tag queue
	always_comb begin
		ch_req       = win_req;
		ch_req.valid = win_req.valid && (win_req.is_write || tag_in_grant);
	end

	assign ch_xfer = ch_req.valid && ch_req_grant;

	always_comb begin
		for (int i = 0; i < aos_pkg::NUM_APPS; i++)
			app_req_grant[i] = ch_xfer && (winner == aos_pkg::app_id_t'(i));
	end

	always_ff @(posedge clk_main_a0) begin
		if (!rst_main_n) begin
			rr_ptr  <= '0;
			locked  <= 1'b0;
			lock_id <= '0;
		end else if (ch_xfer) begin
			rr_ptr <= aos_pkg::app_id_t'((int'(winner) + 1) % aos_pkg::NUM_APPS);
			locked <= 1'b0;
		end else if (ch_req.valid) begin
			locked  <= 1'b1;
			lock_id <= winner;
		end
	end

	// ------------------------------
	// Response return by tag
	// ------------------------------
	sync_fifo #(
		.T(aos_pkg::app_id_t)
	) tag_fifo_i (
		.clk_main_a0 (clk_main_a0),
		.rst_main_n  (rst_main_n),
		.in_data     (winner),
		.in_valid    (ch_xfer && !win_req.is_write),
		.in_grant    (tag_in_grant),
		.out_data    (tag_head),
		.out_valid   (tag_head_valid),
		.out_grant   (tag_pop)
	);

	assign ch_resp_grant = tag_head_valid && app_resp_grant[tag_head];
	assign tag_pop       = ch_resp.valid && ch_resp_grant;

	always_comb begin
		for (int i = 0; i < aos_pkg::NUM_APPS; i++) begin
			app_mem_resp[i].data  = ch_resp.data;
			app_mem_resp[i].valid = ch_resp.valid && tag_head_valid
				&& (tag_head == aos_pkg::app_id_t'(i));
		end
	end

endmodule

`default_nettype wire

/* hw/mem_drive.sv */
// Memory drive application
// Writes a run of pattern words or reads a run back and sums it,
// all under control of its soft registers
`timescale 1ns/1ps
`default_nettype none

module mem_drive (
	input  wire logic                  clk_main_a0,
	input  wire logic                  rst_main_n,
	input  wire aos_pkg::softreg_req_t sr_req,
	output aos_pkg::softreg_resp_t     sr_resp,
	output aos_pkg::mem_req_t          mem_req,
	input  wire logic                  mem_req_grant,
	input  wire aos_pkg::mem_resp_t    mem_resp,
	output logic                       mem_resp_grant
);

	logic [aos_pkg::REG_IDX_W-1:0]   reg_idx;
	logic                            reg_wr;

	// Configuration registers
	logic [aos_pkg::SR_DATA_W-1:0]   base_q;
	logic [aos_pkg::SR_DATA_W-1:0]   count_q;
	logic [aos_pkg::SR_DATA_W-1:0]   pattern_q;

	// Run state
	logic                            busy;
	logic                            run_write;
	logic [aos_pkg::SR_DATA_W-1:0]   issue_cnt;
	logic [aos_pkg::SR_DATA_W-2:0]   done_cnt;
	logic [aos_pkg::SR_DATA_W-1:0]   sum_q;
	logic                            issue_xfer;

	// Read-back path
	logic [aos_pkg::SR_DATA_W-1:0]   rd_data;
	logic                            resp_valid_q;
	logic [aos_pkg::SR_DATA_W-1:0]   resp_data_q;

	assign reg_idx = sr_req.addr[aos_pkg::REG_IDX_LSB +: aos_pkg::REG_IDX_W];
	assign reg_wr  = sr_req.valid && sr_req.is_write;

	// ------------------------------
	// Memory request generation
	// ------------------------------
	// Held steady until granted, issue counter is the word index
	always_comb begin
		mem_req.valid    = busy && (issue_cnt != count_q);
		mem_req.is_write = run_write;
		mem_req.addr     = base_q[aos_pkg::MEM_ADDR_W-1:0]
			+ issue_cnt[aos_pkg::MEM_ADDR_W-1:0];
		mem_req.data     = aos_pkg::MEM_DATA_W'(pattern_q + issue_cnt);
	end

	assign issue_xfer     = mem_req.valid && mem_req_grant;
	// Read data is never refused
	assign mem_resp_grant = 1'b1;

	always_ff @(posedge clk_main_a0) begin
		if (!rst_main_n) begin
			base_q    <= '0;
			count_q   <= '0;
			pattern_q <= '0;
			busy      <= 1'b0;
			run_write <= 1'b0;
			issue_cnt <= '0;
			done_cnt  <= '0;
			sum_q     <= '0;
		end else begin
			// Stalls here while the arbiter withholds grant
			if (issue_xfer)
				issue_cnt <= issue_cnt + 1'b1;
			// Writes finish on grant, reads on return
			if ((issue_xfer && run_write) || mem_resp.valid)
				done_cnt <= done_cnt + 1'b1;
			if (mem_resp.valid)
				sum_q <= sum_q + aos_pkg::SR_DATA_W'(mem_resp.data);
			// All words accounted for
			if (busy && ({1'b0, done_cnt} == count_q))
				busy <= 1'b0;

			// Register writes, start wins over the run updates above
			if (reg_wr) begin
				case (reg_idx)
					aos_pkg::REG_BASE:    base_q    <= sr_req.data;
					aos_pkg::REG_COUNT:   count_q   <= sr_req.data;
					aos_pkg::REG_PATTERN: pattern_q <= sr_req.data;
					aos_pkg::REG_START: begin
						run_write <= sr_req.data[0];
						busy      <= 1'b1;
						issue_cnt <= '0;
						done_cnt  <= '0;
						sum_q     <= '0;
					end
					default: ;
				endcase
			end
		end
	end

	// ------------------------------
	// Soft-register reads
	// ------------------------------
	always_comb begin
		case (reg_idx)
			aos_pkg::REG_BASE:    rd_data = base_q;
			aos_pkg::REG_COUNT:   rd_data = count_q;
			aos_pkg::REG_PATTERN: rd_data = pattern_q;
			aos_pkg::REG_DONE:    rd_data = {busy, done_cnt};
			aos_pkg::REG_SUM:     rd_data = sum_q;
			default:              rd_data = '0;
		endcase
	end

	// One cycle after the request pulse
	always_ff @(posedge clk_main_a0) begin
		if (!rst_main_n)
			resp_valid_q <= 1'b0;
		else
			resp_valid_q <= sr_req.valid && !sr_req.is_write;
	end

	always_ff @(posedge clk_main_a0) begin
		resp_data_q <= rd_data;
	end

	always_comb begin
		sr_resp.valid = resp_valid_q;
		sr_resp.data  = resp_data_q;
	end

endmodule

`default_nettype wire

/* hw/simple_dram.sv */
// Simple DRAM model
// Queued word requests served in order, fixed read latency,
// read data held until the consumer grants it
`timescale 1ns/1ps
`default_nettype none

module simple_dram (
	input  wire logic              clk_main_a0,
	input  wire logic              rst_main_n,
	input  wire aos_pkg::mem_req_t req,
	output logic                   req_grant,
	output aos_pkg::mem_resp_t     resp,
	input  wire logic              resp_grant
);

	localparam int LAT_W = $clog2(aos_pkg::DRAM_LATENCY + 1);

	logic [aos_pkg::MEM_DATA_W-1:0] mem_array [aos_pkg::MEM_DEPTH];
	aos_pkg::mem_req_t              head;
	logic                           head_valid;
	logic                           head_pop;
	// Busy from read exit until its data is taken
	logic                           rd_busy;
	logic                           rd_ready;
	logic [LAT_W-1:0]               lat_cnt;
	logic [aos_pkg::MEM_DATA_W-1:0] rd_data;

	sync_fifo #(
		.T(aos_pkg::mem_req_t)
	) req_fifo_i (
		.clk_main_a0 (clk_main_a0),
		.rst_main_n  (rst_main_n),
		.in_data     (req),
		.in_valid    (req.valid),
		.in_grant    (req_grant),
		.out_data    (head),
		.out_valid   (head_valid),
		.out_grant   (head_pop)
	);

	// One request at a time, stalls behind a pending read
	assign head_pop = head_valid && !rd_busy;

	// Array and read capture
	always_ff @(posedge clk_main_a0) begin
		if (head_pop && head.is_write)
			mem_array[head.addr] <= head.data;
		if (head_pop && !head.is_write)
			rd_data <= mem_array[head.addr];
	end

	// Latency countdown, then hold for grant
	always_ff @(posedge clk_main_a0) begin
		if (!rst_main_n) begin
			rd_busy  <= 1'b0;
			rd_ready <= 1'b0;
			lat_cnt  <= '0;
		end else if (head_pop && !head.is_write) begin
			rd_busy <= 1'b1;
			lat_cnt <= LAT_W'(aos_pkg::DRAM_LATENCY - 1);
		end else if (rd_ready) begin
			if (resp_grant) begin
				rd_busy  <= 1'b0;
				rd_ready <= 1'b0;
			end
		end else if (rd_busy) begin
			if (lat_cnt == '0)
				rd_ready <= 1'b1;
			else
				lat_cnt <= lat_cnt - 1'b1;
		end
	end

	always_comb begin
		resp.valid = rd_ready;
		resp.data  = rd_data;
	end

endmodule

`default_nettype wire

/* hw/softreg_router.sv */
// Soft-register router
// Sends each host request to one application by address,
// merges the application read responses back to the host
`timescale 1ns/1ps
`default_nettype none

module softreg_router (
	input  wire logic                  clk_main_a0,
	input  wire logic                  rst_main_n,
	input  wire aos_pkg::softreg_req_t host_req,
	output aos_pkg::softreg_resp_t     host_resp,
	output aos_pkg::softreg_req_t      app_req [aos_pkg::NUM_APPS],
	input  wire aos_pkg::softreg_resp_t app_resp [aos_pkg::NUM_APPS]
);

	aos_pkg::app_id_t              app_sel;
	aos_pkg::softreg_req_t         req_q;
	logic [aos_pkg::NUM_APPS-1:0]  app_valid_q;

	// Application index sits just above the register index
	assign app_sel = host_req.addr[aos_pkg::APP_SEL_LSB +: aos_pkg::APP_ID_W];

	// ------------------------------
	// Request path, one register stage
	// ------------------------------
	always_ff @(posedge clk_main_a0) begin
		if (!rst_main_n) begin
			app_valid_q <= '0;
		end else begin
			for (int i = 0; i < aos_pkg::NUM_APPS; i++)
				app_valid_q[i] <= host_req.valid && (app_sel == aos_pkg::app_id_t'(i));
		end
	end

	// Shared payload, only the valid is per application
	always_ff @(posedge clk_main_a0) begin
		if (host_req.valid)
			req_q <= host_req;
	end

	always_comb begin
		for (int i = 0; i < aos_pkg::NUM_APPS; i++) begin
			app_req[i]       = req_q;
			app_req[i].valid = app_valid_q[i];
		end
	end

	// ------------------------------
	// Response path, combinational
	// ------------------------------
	// One read outstanding, so at most one app answers
	always_comb begin
		host_resp = '0;
		for (int i = 0; i < aos_pkg::NUM_APPS; i++) begin
			if (app_resp[i].valid)
				host_resp = app_resp[i];
		end
	end

endmodule

`default_nettype wire

/* hw/sync_fifo.sv */
// Synchronous FIFO with valid/grant on both sides
// Payload type is a parameter, depth comes from the package
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter type T = logic
) (
	input  wire logic clk_main_a0,
	input  wire logic rst_main_n,
	input  wire T     in_data,
	input  wire logic in_valid,
	output logic      in_grant,
	output T          out_data,
	output logic      out_valid,
	input  wire logic out_grant
);

	localparam int PTR_W = $clog2(aos_pkg::FIFO_DEPTH);
	localparam int CNT_W = $clog2(aos_pkg::FIFO_DEPTH + 1);

	T                 slots [aos_pkg::FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// Accept while not full, show oldest while not empty
	assign in_grant  = (count != CNT_W'(aos_pkg::FIFO_DEPTH));
	assign out_valid = (count != '0);
	assign out_data  = slots[rd_ptr];
	assign push      = in_valid && in_grant;
	assign pop       = out_valid && out_grant;

	always_ff @(posedge clk_main_a0) begin
		if (!rst_main_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(aos_pkg::FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(aos_pkg::FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Simultaneous push and pop leave the count alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk_main_a0) begin
		if (push)
			slots[wr_ptr] <= in_data;
	end

endmodule

`default_nettype wire

/* verification/aos_props.sv */
// Soft-register timing checks on the shell top level
// Read data comes back exactly two cycles after its request
`timescale 1ns/1ps
`default_nettype none

module aos_props (
	input wire logic                   clk_main_a0,
	input wire logic                   rst_main_n,
	input wire aos_pkg::softreg_req_t  host_req,
	input wire aos_pkg::softreg_resp_t host_resp
);

	logic rd_req;

	// Host read sampled this cycle
	assign rd_req = host_req.valid && !host_req.is_write;

	// ------------------------------
	// Read response timing
	// ------------------------------
	resp_after_read_a: assert property (
		@(posedge clk_main_a0) disable iff (!rst_main_n)
		rd_req |-> ##2 host_resp.valid
	) else $error("host read not answered two cycles after its request");

	// No response without a read two cycles back
	resp_only_for_read_a: assert property (
		@(posedge clk_main_a0) disable iff (!rst_main_n)
		host_resp.valid |-> $past(rd_req, 2)
	) else $error("host response valid with no read two cycles before");

	// Quiet through reset, once the reset edge has been seen
	resp_low_in_reset_a: assert property (
		@(posedge clk_main_a0)
		(!rst_main_n && $past(!rst_main_n)) |-> !host_resp.valid
	) else $error("host response valid while in reset");

endmodule

`default_nettype wire

/* verification/aos_tb.sv */
// Testbench for the memory-test shell
// Drives the host soft-register port through readback and memory runs
`timescale 1ns/1ps
`default_nettype none

module aos_tb;

	// ------------------------------
	// Run sizes and limits
	// ------------------------------
	localparam int RUN3_COUNT  = 16;
	localparam int MAX_COUNT4  = 23;
	// Words moved in tests 3, 4 and 5
	localparam int TOTAL_WORDS = 2 * RUN3_COUNT + 4 * MAX_COUNT4 + RUN3_COUNT;
	localparam int TEST_MARGIN = 200;
	localparam int CYCLE_LIMIT = TOTAL_WORDS * (aos_pkg::DRAM_LATENCY + 2)
		* aos_pkg::NUM_APPS + 5 * TEST_MARGIN;
	localparam int POLL_LIMIT  = 300;

	logic                   clk_main_a0;
	logic                   rst_main_n;
	aos_pkg::softreg_req_t  host_req;
	aos_pkg::softreg_resp_t host_resp;

	int         cycles;
	int         errors;
	int         errors_at_start;
	int         tests_passed;
	int         tests_failed;
	// Reads in flight over the last two cycles
	logic [1:0] rd_pipe;
	// Reset already low at the previous edge
	logic       rst_seen;

	aos_top dut_i (
		.clk_main_a0 (clk_main_a0),
		.rst_main_n  (rst_main_n),
		.host_req    (host_req),
		.host_resp   (host_resp)
	);

	bind aos_top aos_props props_i (
		.clk_main_a0 (clk_main_a0),
		.rst_main_n  (rst_main_n),
		.host_req    (host_req),
		.host_resp   (host_resp)
	);

	always #10 clk_main_a0 = ~clk_main_a0;

	// Run length guard
	always @(posedge clk_main_a0) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run still going after %0d cycles", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	// Response due exactly two edges after the read is sampled
	always @(posedge clk_main_a0) begin
		rst_seen <= !rst_main_n;
		if (!rst_main_n) begin
			rd_pipe <= '0;
			// Response flop cleared by the first reset edge
			if (rst_seen) begin
				assert (host_resp.valid === 1'b0) else begin
					$display("Host read response valid during reset");
					errors++;
				end
			end
		end else begin
			rd_pipe <= {rd_pipe[0], host_req.valid && !host_req.is_write};
			assert (host_resp.valid === rd_pipe[1]) else begin
				$display("Host read response out of step: valid %b, expected %b",
					host_resp.valid, rd_pipe[1]);
				errors++;
			end
		end
	end

	// ------------------------------
	// Soft-register access
	// ------------------------------
	function automatic logic [31:0] reg_addr(input int app, input logic [2:0] idx);
		return 32'((app << aos_pkg::APP_SEL_LSB) | (int'(idx) << aos_pkg::REG_IDX_LSB));
	endfunction

	task automatic write_reg(input int app, input logic [2:0] idx, input logic [63:0] data);
		@(negedge clk_main_a0);
		host_req.valid    = 1'b1;
		host_req.is_write = 1'b1;
		host_req.addr     = reg_addr(app, idx);
		host_req.data     = data;
		@(negedge clk_main_a0);
		host_req.valid = 1'b0;
	endtask

	// Response sits at the second falling edge after the request
	task automatic read_reg(input int app, input logic [2:0] idx, output logic [63:0] data);
		@(negedge clk_main_a0);
		host_req.valid    = 1'b1;
		host_req.is_write = 1'b0;
		host_req.addr     = reg_addr(app, idx);
		host_req.data     = '0;
		@(negedge clk_main_a0);
		host_req.valid = 1'b0;
		@(negedge clk_main_a0);
		assert (host_resp.valid === 1'b1) else begin
			$display("No read response from app %0d register %0d", app, idx);
			errors++;
		end
		data = host_resp.data;
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected) else begin
			$display("Mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_reg(input int app, input logic [2:0] idx, input string name,
		input logic [63:0] expected);
		logic [63:0] got;
		read_reg(app, idx, got);
		check_value($sformatf("app%0d %s", app, name), expected, got);
	endtask

	// ------------------------------
	// Memory runs
	// ------------------------------
	function automatic logic [63:0] expected_sum(input logic [63:0] count,
		input logic [63:0] pattern);
		return count * pattern + (count * (count - 1)) / 2;
	endfunction

	task automatic setup_run(input int app, input logic [63:0] base,
		input logic [63:0] count, input logic [63:0] pattern);
		write_reg(app, aos_pkg::REG_BASE, base);
		write_reg(app, aos_pkg::REG_COUNT, count);
		write_reg(app, aos_pkg::REG_PATTERN, pattern);
	endtask

	// Poll busy until it drops
	task automatic wait_run_done(input int app);
		logic [63:0] done;
		int          polls;
		done  = {1'b1, 63'd0};
		polls = 0;
		while (done[63] && polls < POLL_LIMIT) begin
			read_reg(app, aos_pkg::REG_DONE, done);
			polls++;
		end
		assert (!done[63]) else begin
			$display("App %0d run did not finish after %0d polls", app, polls);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		if (errors == errors_at_start) begin
			tests_passed++;
			$display("Test %s: passed", name);
		end else begin
			tests_failed++;
			$display("Test %s: FAILED with %0d errors", name, errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial begin
		logic [63:0] vals [3];
		logic [63:0] base3;
		logic [63:0] pat3;
		logic [63:0] base4 [2];
		logic [63:0] count4 [2];
		logic [63:0] pat4 [2];

		void'($urandom(99794));
		clk_main_a0     = 1'b0;
		rst_main_n      = 1'b0;
		host_req        = '0;
		cycles          = 0;
		errors          = 0;
		errors_at_start = 0;
		tests_passed    = 0;
		tests_failed    = 0;
		repeat (5) @(posedge clk_main_a0);
		@(negedge clk_main_a0);
		rst_main_n = 1'b1;

		// Quiet after reset
		repeat (5) begin
			@(negedge clk_main_a0);
			check_value("host_resp.valid", 64'd0, 64'(host_resp.valid));
		end
		for (int a = 0; a < aos_pkg::NUM_APPS; a++)
			check_reg(a, aos_pkg::REG_DONE, "REG_DONE", 64'd0);
		end_test("1 reset state");

		for (int a = 0; a < aos_pkg::NUM_APPS; a++) begin
			for (int r = 0; r < 3; r++) begin
				vals[r] = {$urandom, $urandom};
				write_reg(a, 3'(r), vals[r]);
			end
			check_reg(a, aos_pkg::REG_BASE, "REG_BASE", vals[0]);
			check_reg(a, aos_pkg::REG_COUNT, "REG_COUNT", vals[1]);
			check_reg(a, aos_pkg::REG_PATTERN, "REG_PATTERN", vals[2]);
		end
		end_test("2 register readback");

		// Low region that test 5 reads again
		base3 = 64'($urandom_range(0, 47));
		pat3  = {$urandom, $urandom};
		setup_run(0, base3, RUN3_COUNT, pat3);
		write_reg(0, aos_pkg::REG_START, 64'd1);
		wait_run_done(0);
		check_reg(0, aos_pkg::REG_DONE, "REG_DONE", 64'(RUN3_COUNT));
		write_reg(0, aos_pkg::REG_START, 64'd0);
		wait_run_done(0);
		check_reg(0, aos_pkg::REG_DONE, "REG_DONE", 64'(RUN3_COUNT));
		check_reg(0, aos_pkg::REG_SUM, "REG_SUM", expected_sum(RUN3_COUNT, pat3));
		end_test("3 single app run");

		// Disjoint regions above the test 3 words
		base4[0] = 64'($urandom_range(100, 400));
		base4[1] = 64'($urandom_range(512, 900));
		for (int a = 0; a < 2; a++) begin
			count4[a] = 64'($urandom_range(8, MAX_COUNT4));
			pat4[a]   = {$urandom, $urandom};
			setup_run(a, base4[a], count4[a], pat4[a]);
		end
		write_reg(0, aos_pkg::REG_START, 64'd1);
		write_reg(1, aos_pkg::REG_START, 64'd1);
		wait_run_done(0);
		wait_run_done(1);
		write_reg(0, aos_pkg::REG_START, 64'd0);
		write_reg(1, aos_pkg::REG_START, 64'd0);
		wait_run_done(0);
		wait_run_done(1);
		for (int a = 0; a < 2; a++) begin
			check_reg(a, aos_pkg::REG_DONE, "REG_DONE", count4[a]);
			check_reg(a, aos_pkg::REG_SUM, "REG_SUM", expected_sum(count4[a], pat4[a]));
		end
		end_test("4 concurrent runs");

		// App 1 reads what app 0 wrote
		setup_run(1, base3, RUN3_COUNT, {$urandom, $urandom});
		write_reg(1, aos_pkg::REG_START, 64'd0);
		wait_run_done(1);
		check_reg(1, aos_pkg::REG_SUM, "REG_SUM", expected_sum(RUN3_COUNT, pat3));
		end_test("5 shared memory");

		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hw/aos_pkg.sv
hw/sync_fifo.sv
hw/softreg_router.sv
hw/mem_drive.sv
hw/mem_arbiter.sv
hw/simple_dram.sv
hw/aos_top.sv
verification/aos_props.sv
verification/aos_tb.sv
